/* Bender.yml */
package:
  name: color_tracker

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/pixel_pkg.sv
      - design/track_pkg.sv
      - design/pixelGrader.sv
      - design/rasterCounter.sv
      - design/subFrameAccum.sv
      - design/candidateSearch.sv
      - design/trackControl.sv
      - design/colorTracker.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_colorTracker.sv

/* design/candidateSearch.sv */
`default_nettype none

`include "tracker_params.svh"

module candidateSearch
  import pixel_pkg::*;
  import track_pkg::*;
(
  input  wire logic  i_clk,
  input  wire logic  i_rst_n,
  input  wire logic  i_clear,
  input  wire coordT i_hPos,
  input  wire coordT i_vPos,
  input  wire coordT i_originH,
  input  wire coordT i_originV,
  input  wire gradeT i_grade,
  input  wire logic  i_gradeVal,
  output coordT      o_bestH,
  output coordT      o_bestV,
  output logic       o_found,
  output logic       o_scanDone,
  output logic       o_redSeen
);

  // row one at 0..6, row two at 7..13
  localparam int numSf   = 2 * `RANGE_H;
  localparam int lastCol = `RANGE_H - 1;

  coordT            startH [numSf];
  coordT            startV [numSf];
  coordT            offV   [numSf];
  sumT              sum    [numSf];
  logic [numSf-1:0] done;
  logic [numSf-1:0] redSeen;
  logic [numSf-1:0] foldOk;
  logic [numSf-1:0] foldSel;
  logic [numSf-1:0] sfClear;
  coordT            vLimit;
  sumT              maxSum;

  assign vLimit = i_originV + coordT'(`SEARCH_V);

  // ==============================
  // sub-frame grid
  // ==============================
  for (genvar k = 0; k < numSf; k++) begin : g_sf
    assign startH[k]  = i_originH + coordT'((k % `RANGE_H) * `OVERLAP_H);
    assign startV[k]  = i_originV + offV[k];
    assign foldOk[k]  = done[k] && (startV[k] <= vLimit);
    assign sfClear[k] = i_clear || foldSel[k];

    subFrameAccum u_subFrameAccum (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_clear    (sfClear[k]),
      .i_hPos     (i_hPos),
      .i_vPos     (i_vPos),
      .i_startH   (startH[k]),
      .i_startV   (startV[k]),
      .i_grade    (i_grade),
      .i_gradeVal (i_gradeVal),
      .o_done     (done[k]),
      .o_sum      (sum[k]),
      .o_redSeen  (redSeen[k])
    );
  end

  // lowest index wins, so row one before row two
  always_comb begin
    foldSel = '0;
    for (int n = 0; n < numSf; n++) begin
      if (foldOk[n] && (foldSel == '0)) begin
        foldSel[n] = 1'b1;
      end
    end
  end

  // ==============================
  // running maximum and row offsets
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      maxSum  <= '0;
      o_bestH <= '0;
      o_bestV <= '0;
      for (int n = 0; n < numSf; n++) begin
        offV[n] <= coordT'((n / `RANGE_H) * `OVERLAP_V);
      end
    end else if (i_clear) begin
      maxSum <= '0; // best point kept for the outputs
      for (int n = 0; n < numSf; n++) begin
        offV[n] <= coordT'((n / `RANGE_H) * `OVERLAP_V);
      end
    end else begin
      for (int n = 0; n < numSf; n++) begin
        if (foldSel[n]) begin
          offV[n] <= offV[n] + coordT'(`SUB_V); // next window down
          if (sum[n] > maxSum) begin
            maxSum  <= sum[n];
            o_bestH <= startH[n];
            o_bestV <= startV[n];
          end
        end
      end
    end
  end

  assign o_found    = (maxSum != '0);
  assign o_scanDone = (startV[lastCol] > vLimit) || (startV[numSf-1] > vLimit);
  assign o_redSeen  = |redSeen;

endmodule

`default_nettype wire

/* design/colorTracker.sv */
`default_nettype none

module colorTracker
  import pixel_pkg::*;
  import track_pkg::*;
(
  input  wire logic i_clk,
  input  wire logic i_rst_n,
  input  wire rgbT  i_rgb,
  input  wire logic i_pixelVal,
  input  wire logic i_start,
  input  wire logic i_hold,
  output tileT      o_pointH,
  output tileT      o_pointV,
  output logic      o_isTracking,
  output logic      o_valid
);

  gradeT grade;
  logic  gradeVal;
  coordT hPos;
  coordT vPos;
  coordT originH;
  coordT originV;
  coordT bestH;
  coordT bestV;
  logic  found;
  logic  scanDone;
  logic  redSeen;
  logic  clear;

  // ==============================
  // front end
  // ==============================
  pixelGrader u_pixelGrader (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rgb      (i_rgb),
    .i_pixelVal (i_pixelVal),
    .o_grade    (grade),
    .o_gradeVal (gradeVal)
  );

  rasterCounter u_rasterCounter (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_pixelVal (i_pixelVal),
    .o_hPos     (hPos),
    .o_vPos     (vPos)
  );

  // ==============================
  // search and control
  // ==============================
  candidateSearch u_candidateSearch (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_clear    (clear),
    .i_hPos     (hPos),
    .i_vPos     (vPos),
    .i_originH  (originH),
    .i_originV  (originV),
    .i_grade    (grade),
    .i_gradeVal (gradeVal),
    .o_bestH    (bestH),
    .o_bestV    (bestV),
    .o_found    (found),
    .o_scanDone (scanDone),
    .o_redSeen  (redSeen)
  );

  trackControl u_trackControl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_start      (i_start),
    .i_hold       (i_hold),
    .i_hPos       (hPos),
    .i_vPos       (vPos),
    .i_bestH      (bestH),
    .i_bestV      (bestV),
    .i_found      (found),
    .i_scanDone   (scanDone),
    .i_redSeen    (redSeen),
    .o_clear      (clear),
    .o_originH    (originH),
    .o_originV    (originV),
    .o_valid      (o_valid),
    .o_isTracking (o_isTracking)
  );

  assign o_pointH = bestH[9:5]; // tile of the tracked point
  assign o_pointV = bestV[9:5];

endmodule

`default_nettype wire

/* design/pixelGrader.sv */
`default_nettype none

`include "tracker_params.svh"

module pixelGrader
  import pixel_pkg::*;
(
  input  wire logic  i_clk,
  input  wire logic  i_rst_n,
  input  wire rgbT   i_rgb,
  input  wire logic  i_pixelVal,
  output gradeT      o_grade,
  output logic       o_gradeVal
);

  logic [7:0] blueMinusRed;
  logic [7:0] blueMinusGreen;
  logic [7:0] redMinusBlue;
  logic [7:0] redMinusGreen;
  logic [7:0] blueDiff;
  logic [7:0] redDiff;

  // clamped channel differences
  assign blueMinusRed   = (i_rgb.blue > i_rgb.red)   ? i_rgb.blue - i_rgb.red   : 8'd0;
  assign blueMinusGreen = (i_rgb.blue > i_rgb.green) ? i_rgb.blue - i_rgb.green : 8'd0;
  assign redMinusBlue   = (i_rgb.red > i_rgb.blue)   ? i_rgb.red - i_rgb.blue   : 8'd0;
  assign redMinusGreen  = (i_rgb.red > i_rgb.green)  ? i_rgb.red - i_rgb.green  : 8'd0;

  assign blueDiff = (blueMinusRed < blueMinusGreen) ? blueMinusRed : blueMinusGreen;
  assign redDiff  = (redMinusBlue < redMinusGreen)  ? redMinusBlue : redMinusGreen;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_grade    <= '0;
      o_gradeVal <= 1'b0;
    end else begin
      o_gradeVal <= i_pixelVal;
      if (i_pixelVal && !(blueDiff != 8'd0 && blueDiff == redDiff)) begin
        o_grade.blue <= (blueDiff > 8'(`BLUE_THRESH));
        // red only when not already blue
        o_grade.red  <= (blueDiff <= 8'(`BLUE_THRESH)) && (redDiff > 8'(`RED_THRESH));
      end
    end
  end

endmodule

`default_nettype wire

/* design/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

  // one raster pixel, red in the top byte
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgbT;

  // colour class of a pixel
  typedef struct packed {
    logic blue;
    logic red;
  } gradeT;

endpackage

`default_nettype wire

/* design/rasterCounter.sv */
`default_nettype none

`include "tracker_params.svh"

module rasterCounter
  import track_pkg::*;
(
  input  wire logic i_clk,
  input  wire logic i_rst_n,
  input  wire logic i_pixelVal,
  output coordT     o_hPos,
  output coordT     o_vPos
);

  logic lineEnd;
  logic frameEnd;

  assign lineEnd  = (o_hPos >= coordT'(`FRAME_H));
  assign frameEnd = (o_vPos >= coordT'(`FRAME_V));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_hPos <= '0; // first strobe lands on H 1
      o_vPos <= coordT'(1);
    end else if (i_pixelVal) begin
      if (!lineEnd) begin
        o_hPos <= o_hPos + coordT'(1);
      end else begin
        o_hPos <= coordT'(1);
        o_vPos <= frameEnd ? coordT'(1) : o_vPos + coordT'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* design/subFrameAccum.sv */
`default_nettype none

`include "tracker_params.svh"

module subFrameAccum
  import pixel_pkg::*;
  import track_pkg::*;
(
  input  wire logic  i_clk,
  input  wire logic  i_rst_n,
  input  wire logic  i_clear,
  input  wire coordT i_hPos,
  input  wire coordT i_vPos,
  input  wire coordT i_startH,
  input  wire coordT i_startV,
  input  wire gradeT i_grade,
  input  wire logic  i_gradeVal,
  output logic       o_done,
  output sumT        o_sum,
  output logic       o_redSeen
);

  logic [12:0] blueCnt; // up to 64*64
  logic [12:0] redCnt;
  logic [10:0] endH;
  logic [10:0] endV;
  logic        inWindow;
  logic        pastWindow;

  assign endH = {1'b0, i_startH} + 11'(`SUB_H);
  assign endV = {1'b0, i_startV} + 11'(`SUB_V);

  assign inWindow = (i_hPos >= i_startH) && ({1'b0, i_hPos} < endH) &&
                    (i_vPos >= i_startV) && ({1'b0, i_vPos} < endV);

  // below the window, or on its last line right of it
  assign pastWindow = ({1'b0, i_vPos} >= endV) ||
                      (({1'b0, i_vPos} == endV - 11'd1) && ({1'b0, i_hPos} >= endH));

  assign o_sum     = blueCnt[12:5];
  assign o_redSeen = (redCnt > 13'(`RED_LIMIT));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      blueCnt <= '0;
      redCnt  <= '0;
      o_done  <= 1'b0;
    end else if (i_clear) begin
      blueCnt <= '0;
      redCnt  <= '0;
      o_done  <= 1'b0;
    end else begin
      if (pastWindow) begin
        o_done <= 1'b1;
      end
      if (i_gradeVal && inWindow) begin
        blueCnt <= blueCnt + 13'(i_grade.blue);
        redCnt  <= redCnt + 13'(i_grade.red);
      end
    end
  end

endmodule

`default_nettype wire

/* design/trackControl.sv */
`default_nettype none

`include "tracker_params.svh"

module trackControl
  import track_pkg::*;
(
  input  wire logic  i_clk,
  input  wire logic  i_rst_n,
  input  wire logic  i_start,
  input  wire logic  i_hold,
  input  wire coordT i_hPos,
  input  wire coordT i_vPos,
  input  wire coordT i_bestH,
  input  wire coordT i_bestV,
  input  wire logic  i_found,
  input  wire logic  i_scanDone,
  input  wire logic  i_redSeen,
  output logic       o_clear,
  output coordT      o_originH,
  output coordT      o_originV,
  output logic       o_valid,
  output logic       o_isTracking
);

  localparam coordT maxOriginH = coordT'(`FRAME_H - `SEARCH_H);
  localparam coordT maxOriginV = coordT'(`FRAME_V - `SEARCH_V);

  trackStateT state;
  logic       holdQ;
  logic       lastLine;
  coordT      nextH;
  coordT      nextV;

  assign lastLine = (i_vPos == coordT'(`FRAME_V));

  // best point less margin, clamped into the frame
  assign nextH = (i_bestH < coordT'(`MARGIN)) ? '0 :
                 (i_bestH - coordT'(`MARGIN) > maxOriginH) ? maxOriginH :
                 i_bestH - coordT'(`MARGIN);
  assign nextV = (i_bestV < coordT'(`MARGIN)) ? '0 :
                 (i_bestV - coordT'(`MARGIN) > maxOriginV) ? maxOriginV :
                 i_bestV - coordT'(`MARGIN);

  assign o_clear = (state != SCAN) || holdQ;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= IDLE;
      holdQ     <= 1'b0;
      o_valid   <= 1'b0;
      o_originH <= coordT'(`FRAME_H / 2 - 3 * `OVERLAP_H);
      o_originV <= coordT'(`FRAME_V / 2 - 3 * `OVERLAP_V);
    end else begin
      holdQ <= i_hold;
      case (state)
        IDLE: if (i_start) state <= SCAN;
        SCAN: begin
          if (holdQ) begin
            state   <= IDLE;
            o_valid <= 1'b0;
          end else if (i_scanDone) begin
            state   <= UPDATE;
            o_valid <= 1'b1;
          end else if (lastLine && i_hPos == coordT'(`FRAME_H - 1)) begin
            state <= UPDATE; // frame ran out, no point
          end
        end
        UPDATE: begin
          if (i_found) begin
            o_originH <= nextH;
            o_originV <= nextV;
          end
          if (holdQ) begin
            state   <= IDLE;
            o_valid <= 1'b0;
          end else if (lastLine && i_hPos == coordT'(`FRAME_H)) begin
            state   <= SCAN;
            o_valid <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_isTracking <= 1'b0;
    end else if (i_start) begin
      o_isTracking <= 1'b1;
    end else if (state == SCAN && (i_redSeen || holdQ)) begin
      o_isTracking <= 1'b0;
    end else if (state == UPDATE) begin
      o_isTracking <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/track_pkg.sv */
`default_nettype none

package track_pkg;

  // 1-based raster coordinate
  typedef logic [9:0] coordT;

  // coordinate / 32
  typedef logic [4:0] tileT;

  // blue count / 32
  typedef logic [7:0] sumT;

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    UPDATE
  } trackStateT;

endpackage

`default_nettype wire

/* include/tracker_params.svh */
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

// ==============================
// raster
// ==============================
`define FRAME_H 640
`define FRAME_V 480

// ==============================
// sub-frame grid
// ==============================
`define SUB_H 64
`define SUB_V 64
`define OVERLAP_H 32 // column pitch
`define OVERLAP_V 32 // row two stagger
`define RANGE_H 7    // columns per row

// search span and re-centring
`define SEARCH_H 224
`define SEARCH_V 224
`define MARGIN 96

// ==============================
// grading
// ==============================
`define BLUE_THRESH 16
`define RED_THRESH 90
`define RED_LIMIT 30 // red pixels per sub-frame

`endif

/* verif/tb_colorTracker.sv */
`default_nettype none

`include "tracker_params.svh"

module tb_colorTracker
  import pixel_pkg::*;
  import track_pkg::*;
();

  localparam int numPix        = `FRAME_H * `FRAME_V;
  localparam int timeoutCycles = 2 * numPix; // two frames of clocks

  // action and colour codes
  localparam int actRun   = 0;
  localparam int actHold  = 1;
  localparam int actStart = 2;
  localparam int colNone  = 0;
  localparam int colBlue  = 1;
  localparam int colRed   = 2;

  logic i_clk;
  logic i_rst_n;
  rgbT  i_rgb;
  logic i_pixelVal;
  logic i_start;
  logic i_hold;
  tileT o_pointH;
  tileT o_pointV;
  logic o_isTracking;
  logic o_valid;

  int errCount;
  int checkCount;
  int frameNo;
  bit timedOut;

  colorTracker u_colorTracker (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_rgb        (i_rgb),
    .i_pixelVal   (i_pixelVal),
    .i_start      (i_start),
    .i_hold       (i_hold),
    .o_pointH     (o_pointH),
    .o_pointV     (o_pointV),
    .o_isTracking (o_isTracking),
    .o_valid      (o_valid)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  // ==============================
  // stimulus and checks
  // ==============================
  function automatic rgbT pixelColor(input int h, input int v, input int colour,
                                     input int bh, input int bv);
    rgbT px;
    px = '0;
    if (h >= bh && h < bh + `SUB_H && v >= bv && v < bv + `SUB_V) begin
      if (colour == colBlue) px.blue = 8'hff;
      else if (colour == colRed) px.red = 8'hff;
    end
    return px;
  endfunction

  task automatic checkTile(input string sigName, input tileT got, input tileT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAILED %s frame %0d: got 0x%0h expected 0x%0h", sigName, frameNo, got, exp);
    end
  endtask

  task automatic checkFlag(input string sigName, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAILED %s frame %0d: got 0x%0h expected 0x%0h", sigName, frameNo, got, exp);
    end
  endtask

  // one full frame in raster order with outputs watched at every falling edge
  task automatic runFrame(input int action, input int colour, input int bh, input int bv,
                          input logic expValid, input tileT expH, input tileT expV,
                          input logic expTrk);
    int   pixIdx;
    int   cycles;
    int   h;
    int   v;
    logic seenValid;
    logic capTrk;
    logic lastTrk;
    logic trkSeen;
    logic unstable;
    tileT capH;
    tileT capV;
    pixIdx    = 0;
    cycles    = 0;
    seenValid = 1'b0;
    capTrk    = 1'b0;
    lastTrk   = 1'b0;
    trkSeen   = 1'b0;
    unstable  = 1'b0;
    capH      = '0;
    capV      = '0;
    while (pixIdx < numPix && !timedOut) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > timeoutCycles) begin
        timedOut = 1'b1;
        errCount++;
        $display("frame %0d did not finish within two frames of clock cycles", frameNo);
      end else begin
        if (cycles > 1) begin // first sample still shows the previous frame
          if (o_valid && !seenValid) begin
            seenValid = 1'b1;
            capH      = o_pointH;
            capV      = o_pointV;
            capTrk    = o_isTracking;
          end else if (o_valid && !unstable && (o_pointH !== capH || o_pointV !== capV)) begin
            unstable = 1'b1;
            checkTile("o_pointH held", o_pointH, capH);
            checkTile("o_pointV held", o_pointV, capV);
          end
          lastTrk = o_isTracking;
          trkSeen = trkSeen | o_isTracking;
        end
        i_hold  = (action == actHold);
        i_start = (action == actStart) && (pixIdx == 0);
        if (pixIdx > 0 && ($urandom % 8) == 0) begin
          i_pixelVal = 1'b0; // strobe gap
          i_rgb      = '0;
        end else begin
          h          = pixIdx % `FRAME_H + 1;
          v          = pixIdx / `FRAME_H + 1;
          i_rgb      = pixelColor(h, v, colour, bh, bv);
          i_pixelVal = 1'b1;
          pixIdx++;
        end
      end
    end
    if (!timedOut) begin
      checkFlag("o_valid", seenValid, expValid);
      if (expValid && seenValid) begin
        checkTile("o_pointH", capH, expH);
        checkTile("o_pointV", capV, expV);
        checkFlag("o_isTracking", capTrk, expTrk);
      end else if (!expValid && action == actHold) begin
        checkFlag("o_isTracking", lastTrk, expTrk); // dropped by the end of the frame
      end else if (!expValid) begin
        checkFlag("o_isTracking", trkSeen, expTrk); // idle frame, low throughout
      end
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    int           fd;
    int           code;
    int           action;
    int           colour;
    int           bh;
    int           bv;
    int           ev;
    int           eh;
    int           evv;
    int           et;
    bit           fileEnd;
    logic [63:0]  word;
    logic [63:0]  colourWord;
    logic [1599:0] rest;
    void'($urandom(95));
    i_rst_n    = 1'b0;
    i_rgb      = '0;
    i_pixelVal = 1'b0;
    i_start    = 1'b0;
    i_hold     = 1'b0;
    errCount   = 0;
    checkCount = 0;
    frameNo    = 0;
    timedOut   = 1'b0;
    fileEnd    = 1'b0;
    repeat (2) @(negedge i_clk);
    i_rst_n = 1'b1;

    fd = $fopen("verif/trackerVectors.txt", "r");
    if (fd == 0) begin
      errCount++;
      $display("could not open the vector file");
    end else begin
      while (!timedOut && !fileEnd) begin
        code = $fscanf(fd, "%s", word);
        if (code != 1) begin
          fileEnd = 1'b1;
        end else if (word == "#") begin
          code = $fgets(rest, fd); // comment line
        end else begin
          code = $fscanf(fd, "%s %d %d %d %d %d %d", colourWord, bh, bv, ev, eh, evv, et);
          action = (word == "hold") ? actHold : (word == "start") ? actStart : actRun;
          colour = (colourWord == "blue") ? colBlue : (colourWord == "red") ? colRed : colNone;
          if (code != 7 || !(word == "run" || word == "hold" || word == "start")) begin
            errCount++;
            $display("vector line %0d is malformed", frameNo + 1);
            fileEnd = 1'b1;
          end else begin
            frameNo++;
            runFrame(action, colour, bh, bv, ev[0], tileT'(eh), tileT'(evv), et[0]);
          end
        end
      end
      $fclose(fd);
      if (frameNo == 0) begin
        errCount++;
        $display("the vector file held no frames");
      end
    end

    $display("frames %0d, checks %0d, errors %0d", frameNo, checkCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/trackerVectors.txt */
# action colour blobH blobV expValid expPointH expPointV expIsTracking
# blob position is the 1-based top-left pixel, tiles in decimal
run none 0 0 0 0 0 0
# origin 224,144 after reset
start blue 288 208 1 9 6 1
# origin 192,112
run blue 192 112 1 6 3 1
# origin 96,16, red drops tracking, point kept
run red 128 80 1 6 3 0
run none 0 0 1 6 3 1
run blue 224 112 1 7 3 1
# origin 128,16, hold then an idle frame
hold none 0 0 0 0 0 0
run blue 288 144 0 0 0 0
start blue 288 144 1 9 4 1
# origin 192,48, next one clamps V to 0
run blue 288 48 1 9 1 1
run blue 192 32 1 6 1 1

/* vlog.f */
+incdir+include
design/pixel_pkg.sv
design/track_pkg.sv
design/pixelGrader.sv
design/rasterCounter.sv
design/subFrameAccum.sv
design/candidateSearch.sv
design/trackControl.sv
design/colorTracker.sv
verif/tb_colorTracker.sv
